// ==== dv/frogger_chk.sv ====
/*
 * Frogger protocol checks
 * Serial framing of the MAX7219 link and level update timing
 */
`timescale 1ns/1ps

module frogger_chk (
	input logic                      clock_50,
	input logic                      arst_n,
	input logic                      max7219_ncs,
	input logic                      max7219_clk,
	input logic                      level_load,
	input frogger_pkg::game_status_t status
);

	// Gap between words, 2 * SCLK_HALF cycles with ncs high
	assert property (@(posedge clock_50) disable iff (!arst_n)
		$rose(max7219_ncs) |-> max7219_ncs [* (2 * frogger_pkg::SCLK_HALF)])
		else $error("ncs gap shorter than %0d cycles", 2 * frogger_pkg::SCLK_HALF);

	// Chip clock idles low between words
	assert property (@(posedge clock_50) disable iff (!arst_n)
		max7219_ncs |-> !max7219_clk)
		else $error("chip clock high while ncs is high");

	// Level moves only together with a load pulse
	assert property (@(posedge clock_50) disable iff (!arst_n)
		$changed(status.level) |-> level_load)
		else $error("level changed without level_load");

endmodule

// ==== dv/frogger_input.txt ====
# button count wait level game_over
# status checked after the wait that follows the last strobe
none 1 1000 0 0
none 1 1100 0 0
none 1 2100 0 0
start 1 200 0 0
down 1 10 0 0
left 4 10 0 0
right 3 10 0 0
up 7 10 0 1
left 2 10 0 1
start 1 40 0 0
left 1 10 0 0
up 3 10 0 0
right 1 10 0 0
up 3 10 0 0
left 1 10 0 0
up 1 40 1 0
up 2 10 1 0
right 1 10 1 0
up 4 10 1 0
left 2 10 1 0
up 1 40 2 0
up 5 10 2 0
right 2 10 2 0
up 2 40 3 0
right 4 10 3 0
up 2 10 3 0
left 1 10 3 0
up 4 10 3 0
left 1 10 3 0
up 1 40 0 0
none 1 2200 0 0

// ==== dv/frogger_tb.sv ====
/*
 * Frogger testbench
 * Steps from the stimulus file, cycle model of the game,
 * serial word decoder and status checks
 */
`timescale 1ns/1ps

module frogger_tb;

	logic clock_50;
	logic arst_n;
	frogger_pkg::buttons_t buttons;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	frogger_pkg::game_status_t status;

	int value_errors = 0;
	int other_errors = 0;
	int words_seen = 0;
	logic run_ok;

	// Game model
	frogger_pkg::frame_t m_bg;
	frogger_pkg::frame_t snap_frame;
	frogger_pkg::frame_t word_frame;
	logic [2:0] m_row;
	logic [2:0] m_col;
	logic [1:0] m_level;
	logic m_over;
	logic m_load;
	int m_cnt;

	// Decoder state
	logic [15:0] dec_word;
	int dec_bits;
	logic ncs_q;
	logic clk_q;

	tb_clock_gen clock_gen_inst (.clk(clock_50));

	frogger_top frogger_top_inst (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.buttons     (buttons),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.status      (status)
	);

	bind frogger_top frogger_chk frogger_chk_inst (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.level_load  (level_load),
		.status      (status)
	);

	task automatic report_value(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		value_errors++;
		$display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, got);
	endtask

	// ========================================================================
	// Game rules
	// ========================================================================
	// Up has priority over down
	// Left moves toward column 7
	function automatic logic [2:0] moved_row(input logic [2:0] row,
			input frogger_pkg::buttons_t b);
		if (b.up && row < 3'd7)
			return row + 3'd1;
		if (b.down && row > 3'd0)
			return row - 3'd1;
		return row;
	endfunction

	function automatic logic [2:0] moved_col(input logic [2:0] col,
			input frogger_pkg::buttons_t b);
		if (b.left && col < 3'd7)
			return col + 3'd1;
		if (b.right && col > 3'd0)
			return col - 3'd1;
		return col;
	endfunction

	function automatic frogger_pkg::frame_t rotate_down(input frogger_pkg::frame_t f);
		frogger_pkg::frame_t r;
		for (int i = 0; i < 7; i++)
			r[i] = f[i + 1];
		r[7] = f[0];
		return r;
	endfunction

	function automatic frogger_pkg::frame_t overlay(input frogger_pkg::frame_t f,
			input logic [2:0] row, input logic [2:0] col);
		frogger_pkg::frame_t r;
		r = f;
		r[row][col] = 1'b1;
		return r;
	endfunction

	always @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			m_bg <= frogger_pkg::LEVEL_FRAMES[0];
			m_cnt <= 0;
			m_row <= 3'd0;
			m_col <= 3'd4;
			m_level <= 2'd0;
			m_over <= 1'b0;
			m_load <= 1'b0;
		end else begin
			m_load <= 1'b0;
			if (buttons.start) begin
				m_over <= 1'b0;
				m_level <= 2'd0;
				m_row <= 3'd0;
				m_col <= 3'd4;
				m_load <= 1'b1;
			end else if (!m_over) begin
				if (!m_load && m_bg[m_row][m_col]) begin
					m_over <= 1'b1;
				end else if (!m_load && m_row == 3'd7) begin
					m_level <= m_level + 2'd1;
					m_row <= 3'd0;
					m_col <= 3'd4;
					m_load <= 1'b1;
				end else begin
					m_row <= moved_row(m_row, buttons);
					m_col <= moved_col(m_col, buttons);
				end
			end
			// Background follows the level one cycle after the load pulse
			if (m_load) begin
				m_bg <= frogger_pkg::LEVEL_FRAMES[m_level];
				m_cnt <= 0;
			end else if (!m_over) begin
				if (m_cnt == 2047) begin
					m_bg <= rotate_down(m_bg);
					m_cnt <= 0;
				end else begin
					m_cnt <= m_cnt + 1;
				end
			end
		end
	end

	// Displayed frame as seen by the driver before this edge
	always @(posedge clock_50) begin
		snap_frame = overlay(m_bg, m_row, m_col);
	end

	// ========================================================================
	// Serial decoder
	// ========================================================================
	function automatic logic [15:0] setup_word(input int i);
		case (i)
			0: return 16'h0900;
			1: return 16'h0A0A;
			2: return 16'h0B07;
			3: return 16'h0C01;
			default: return 16'h0F00;
		endcase
	endfunction

	task automatic check_word();
		logic [15:0] exp;
		int d;
		assert (dec_bits == 16) else begin
			other_errors++;
			$display("Serial word at %0t ns had %0d bits instead of 16", $time, dec_bits);
		end
		if (words_seen < 5) begin
			exp = setup_word(words_seen);
			assert (dec_word == exp) else report_value("setup word", exp, dec_word);
		end else begin
			d = ((words_seen - 5) % 8) + 1;
			exp[15:8] = 8'(d);
			for (int r = 0; r < 8; r++)
				exp[r] = word_frame[r][8 - d];
			assert (dec_word == exp) else report_value("digit word", exp, dec_word);
		end
		words_seen++;
	endtask

	always @(negedge clock_50) begin
		if (!arst_n) begin
			ncs_q = 1'b1;
			clk_q = 1'b0;
			dec_bits = 0;
			dec_word = '0;
		end else begin
			if (ncs_q && !max7219_ncs) begin
				word_frame = snap_frame;
				dec_bits = 0;
				dec_word = '0;
			end
			// Chip samples din on the rising chip clock
			if (!clk_q && max7219_clk && !max7219_ncs) begin
				dec_word = {dec_word[14:0], max7219_din};
				dec_bits++;
			end
			if (!ncs_q && max7219_ncs)
				check_word();
			ncs_q = max7219_ncs;
			clk_q = max7219_clk;
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	task automatic wait_for_words(input int count, input int limit, output logic ok);
		int n;
		n = 0;
		while (words_seen < count && n < limit) begin
			@(posedge clock_50);
			n++;
		end
		ok = (words_seen >= count);
		if (!ok)
			$display("Timeout after %0d cycles waiting for %0d serial words", limit, count);
	endtask

	task automatic run_step(input logic [63:0] name, input int count, input int wait_n,
			input int lvl, input int go);
		frogger_pkg::buttons_t b;
		int n;
		b = '0;
		case (name)
			"start": b.start = 1'b1;
			"up": b.up = 1'b1;
			"down": b.down = 1'b1;
			"left": b.left = 1'b1;
			"right": b.right = 1'b1;
			"none": b = '0;
			default: begin
				other_errors++;
				$display("Unknown button name %0s in stimulus file", name);
			end
		endcase
		for (int i = 0; i < count; i++) begin
			@(posedge clock_50);
			#1 buttons = b;
			@(posedge clock_50);
			#1 buttons = '0;
			n = 0;
			while (n < wait_n) begin
				@(posedge clock_50);
				n++;
			end
		end
		#1;
		assert (status.level == 2'(lvl)) else report_value("status.level", lvl, status.level);
		assert (status.game_over == 1'(go))
			else report_value("status.game_over", go, status.game_over);
		assert (status.level == m_level) else report_value("model level", m_level, status.level);
		assert (status.game_over == m_over)
			else report_value("model game_over", m_over, status.game_over);
	endtask

	task automatic run_file();
		int fd;
		int rc;
		int count;
		int wait_n;
		int lvl;
		int go;
		logic [8*96-1:0] line_buf;
		logic [63:0] name;
		fd = $fopen("dv/frogger_input.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Cannot open stimulus file dv/frogger_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				rc = $fgets(line_buf, fd);
				rc = $sscanf(line_buf, "%s %d %d %d %d", name, count, wait_n, lvl, go);
				// Comment and blank lines do not parse into five fields
				if (rc == 5)
					run_step(name, count, wait_n, lvl, go);
			end
			$fclose(fd);
		end
	endtask

	initial begin
		arst_n = 1'b0;
		buttons = '0;
		repeat (2) @(posedge clock_50);
		#1 arst_n = 1'b1;
		assert (status == '0) else report_value("status after reset", 0, status);
		// Setup words and one full refresh
		wait_for_words(13, 3000, run_ok);
		if (run_ok)
			run_file();
		assert (words_seen >= 13) else begin
			other_errors++;
			$display("Only %0d serial words were decoded", words_seen);
		end
		$display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
		if (run_ok && value_errors == 0 && other_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock source
 * Free running clock with a 4 ns period
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

endmodule

// ==== frogger_top.f ====
src/frogger_pkg.sv
src/game_ctrl.sv
src/lane_bank.sv
src/max7219_driver.sv
src/frogger_top.sv
dv/tb_clock_gen.sv
dv/frogger_chk.sv
dv/frogger_tb.sv

// ==== src/frogger_pkg.sv ====
/*
 * Frogger shared definitions
 * Matrix widths, game and driver types, level patterns,
 * MAX7219 register codes and timing constants
 */
package frogger_pkg;

	// ========================================================================
	// Widths and types
	// ========================================================================
	typedef logic [7:0] row_t;
	typedef row_t [7:0] frame_t;
	typedef logic [2:0] idx_t;
	typedef logic [1:0] level_t;
	typedef logic [11:0] scroll_cnt_t;
	typedef logic [7:0] reg_addr_t;
	typedef logic [15:0] word_t;

	typedef struct packed {
		idx_t row;
		idx_t col;
	} frog_pos_t;

	typedef struct packed {
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
	} buttons_t;

	typedef struct packed {
		level_t level;
		logic   game_over;
	} game_status_t;

	typedef enum logic {PLAY, OVER} game_state_e;
	typedef enum logic [1:0] {SETUP, IDLE, SHIFT, GAP} drv_state_e;

	// ========================================================================
	// Game constants
	// ========================================================================
	localparam idx_t IDX_MAX = 3'd7;
	localparam idx_t FROG_START_COL = 3'd4;
	localparam scroll_cnt_t SCROLL_PERIOD = 12'd2048;
	localparam int SCLK_HALF = 2;

	// One frame per level, row 7 first
	localparam frame_t [3:0] LEVEL_FRAMES = {
		{8'b10011011, 8'b01110001, 8'b00001100, 8'b01100100,
		 8'b00000101, 8'b11001100, 8'b00000010, 8'b00000000},
		{8'b01011001, 8'b10110010, 8'b10000001, 8'b01100101,
		 8'b00000000, 8'b11001100, 8'b00100000, 8'b00000000},
		{8'b10011001, 8'b01000100, 8'b00000000, 8'b10000010,
		 8'b00010000, 8'b11100110, 8'b00000000, 8'b00000000},
		{8'b11011011, 8'b00000000, 8'b10001000, 8'b00100100,
		 8'b00000000, 8'b11001100, 8'b00000000, 8'b00000000}
	};

	// MAX7219 registers
	localparam reg_addr_t REG_DIGIT1 = 8'h01;
	localparam reg_addr_t REG_DECODE = 8'h09;
	localparam reg_addr_t REG_INTENSITY = 8'h0A;
	localparam reg_addr_t REG_SCAN_LIMIT = 8'h0B;
	localparam reg_addr_t REG_SHUTDOWN = 8'h0C;
	localparam reg_addr_t REG_TEST = 8'h0F;

	localparam int SETUP_COUNT = 5;
	localparam word_t [0:SETUP_COUNT-1] SETUP_WORDS = {
		{REG_DECODE, 8'h00},
		{REG_INTENSITY, 8'h0A},
		{REG_SCAN_LIMIT, 8'h07},
		{REG_SHUTDOWN, 8'h01},
		{REG_TEST, 8'h00}
	};

endpackage

// ==== src/frogger_top.sv ====
/*
 * Frogger top level
 * Game control, background lanes and MAX7219 driver,
 * with the frog laid over the background for display
 */
`timescale 1ns/1ps

module frogger_top (
	input  logic                      clock_50,
	input  logic                      arst_n,
	input  frogger_pkg::buttons_t     buttons,
	output logic                      max7219_din,
	output logic                      max7219_ncs,
	output logic                      max7219_clk,
	output frogger_pkg::game_status_t status
);

	frogger_pkg::frog_pos_t frog;
	frogger_pkg::frame_t background;
	frogger_pkg::frame_t frog_mask;
	frogger_pkg::frame_t display;
	logic level_load;

	game_ctrl game_ctrl_inst (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.buttons    (buttons),
		.background (background),
		.frog       (frog),
		.status     (status),
		.level_load (level_load)
	);

	lane_bank lane_bank_inst (
		.clock_50   (clock_50),
		.arst_n     (arst_n),
		.level_load (level_load),
		.level      (status.level),
		.game_over  (status.game_over),
		.background (background)
	);

	// Frog overlay, a single lit bit
	always_comb begin
		frog_mask = '0;
		frog_mask[frog.row][frog.col] = 1'b1;
	end

	assign display = background | frog_mask;

	max7219_driver max7219_driver_inst (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.frame       (display),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

// ==== src/game_ctrl.sv ====
/*
 * Frogger game control
 * Frog position with edge clamping, collision and win detection,
 * PLAY/OVER state and level counter
 */
`timescale 1ns/1ps

module game_ctrl (
	input  logic                      clock_50,
	input  logic                      arst_n,
	input  frogger_pkg::buttons_t     buttons,
	input  frogger_pkg::frame_t       background,
	output frogger_pkg::frog_pos_t    frog,
	output frogger_pkg::game_status_t status,
	output logic                      level_load
);

	frogger_pkg::game_state_e state;
	frogger_pkg::level_t level;
	frogger_pkg::frog_pos_t moved;
	frogger_pkg::frog_pos_t start_pos;
	logic hit;
	logic at_top;

	assign start_pos = '{row: '0, col: frogger_pkg::FROG_START_COL};

	// ========================================================================
	// Move decode
	// ========================================================================
	// Left is toward column 7, right toward column 0
	always_comb begin
		moved = frog;
		if (buttons.up && frog.row != frogger_pkg::IDX_MAX) begin
			moved.row = frog.row + 3'd1;
		end else if (buttons.down && frog.row != '0) begin
			moved.row = frog.row - 3'd1;
		end
		if (buttons.left && frog.col != frogger_pkg::IDX_MAX) begin
			moved.col = frog.col + 3'd1;
		end else if (buttons.right && frog.col != '0) begin
			moved.col = frog.col - 3'd1;
		end
	end

	// Overlap with a lit background bit
	assign hit = background[frog.row][frog.col];
	assign at_top = (frog.row == frogger_pkg::IDX_MAX);

	// ========================================================================
	// Game state, frog and level
	// ========================================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= frogger_pkg::PLAY;
			level <= '0;
			frog <= start_pos;
			level_load <= 1'b0;
		end else begin
			level_load <= 1'b0;
			if (buttons.start) begin
				// Restart from level 0 in either state
				state <= frogger_pkg::PLAY;
				level <= '0;
				frog <= start_pos;
				level_load <= 1'b1;
			end else if (state == frogger_pkg::PLAY) begin
				if (level_load) begin
					// Background still holds the old level this cycle
					frog <= moved;
				end else if (hit) begin
					state <= frogger_pkg::OVER;
				end else if (at_top) begin
					// Level 3 wraps back to 0
					level <= level + 2'd1;
					frog <= start_pos;
					level_load <= 1'b1;
				end else begin
					frog <= moved;
				end
			end
		end
	end

	assign status = '{level: level, game_over: (state == frogger_pkg::OVER)};

endmodule

// ==== src/lane_bank.sv ====
/*
 * Frogger background lanes
 * Eight rows loaded from the level pattern, rotated down one row
 * per scroll period while the game runs
 */
`timescale 1ns/1ps

module lane_bank (
	input  logic                clock_50,
	input  logic                arst_n,
	input  logic                level_load,
	input  frogger_pkg::level_t level,
	input  logic                game_over,
	output frogger_pkg::frame_t background
);

	frogger_pkg::scroll_cnt_t scroll_cnt;
	frogger_pkg::frame_t rotated;
	logic scroll_tick;

	// ========================================================================
	// Scroll timing
	// ========================================================================
	assign scroll_tick = (scroll_cnt == frogger_pkg::SCROLL_PERIOD - 12'd1);

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			scroll_cnt <= '0;
		end else if (level_load) begin
			scroll_cnt <= '0;
		end else if (!game_over) begin
			if (scroll_tick) begin
				scroll_cnt <= '0;
			end else begin
				scroll_cnt <= scroll_cnt + 12'd1;
			end
		end
	end

	// ========================================================================
	// Rows
	// ========================================================================
	// Every row moves down by one, row 0 wraps to the top
	assign rotated = {background[0], background[7:1]};

	// Reset shows level 0, as after a start
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			background <= frogger_pkg::LEVEL_FRAMES[0];
		end else if (level_load) begin
			background <= frogger_pkg::LEVEL_FRAMES[level];
		end else if (!game_over && scroll_tick) begin
			background <= rotated;
		end
	end

endmodule

// ==== src/max7219_driver.sv ====
/*
 * MAX7219 serial driver
 * Sends the setup words once, then refreshes digits 1 to 8 forever,
 * one 16-bit word per column, MSB first
 */
`timescale 1ns/1ps

module max7219_driver (
	input  logic                clock_50,
	input  logic                arst_n,
	input  frogger_pkg::frame_t frame,
	output logic                max7219_din,
	output logic                max7219_ncs,
	output logic                max7219_clk
);

	frogger_pkg::drv_state_e state;
	frogger_pkg::word_t shift_reg;
	frogger_pkg::idx_t digit_idx;
	frogger_pkg::idx_t col_sel;
	frogger_pkg::row_t column;
	frogger_pkg::reg_addr_t digit_addr;
	logic [2:0] setup_idx;
	logic [3:0] bit_cnt;
	logic [$clog2(2 * frogger_pkg::SCLK_HALF) - 1:0] div_cnt;

	// ========================================================================
	// Column select
	// ========================================================================
	// Digit d takes bit 8-d of every row, row 7 in the data MSB
	always_comb begin
		col_sel = frogger_pkg::IDX_MAX - digit_idx;
		for (int r = 0; r < 8; r++) begin
			column[r] = frame[r][col_sel];
		end
		digit_addr = frogger_pkg::REG_DIGIT1 + frogger_pkg::reg_addr_t'(digit_idx);
	end

	assign max7219_din = shift_reg[15];

	// ========================================================================
	// Word sequencer and serial framing
	// ========================================================================
	// SETUP and IDLE each load one word and drop ncs
	// din moves on the falling chip clock edge
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= frogger_pkg::GAP;
			shift_reg <= '0;
			digit_idx <= '0;
			setup_idx <= '0;
			bit_cnt <= '0;
			div_cnt <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			case (state)
				frogger_pkg::SETUP, frogger_pkg::IDLE: begin
					if (state == frogger_pkg::SETUP) begin
						shift_reg <= frogger_pkg::SETUP_WORDS[setup_idx];
						setup_idx <= setup_idx + 3'd1;
					end else begin
						shift_reg <= {digit_addr, column};
						digit_idx <= digit_idx + 3'd1;
					end
					max7219_ncs <= 1'b0;
					bit_cnt <= 4'd15;
					div_cnt <= '0;
					state <= frogger_pkg::SHIFT;
				end
				frogger_pkg::SHIFT: begin
					if (div_cnt == frogger_pkg::SCLK_HALF - 1) begin
						div_cnt <= '0;
						if (!max7219_clk) begin
							max7219_clk <= 1'b1;
						end else begin
							max7219_clk <= 1'b0;
							if (bit_cnt == '0) begin
								// Last bit done, chip latches on ncs rising
								max7219_ncs <= 1'b1;
								state <= frogger_pkg::GAP;
							end else begin
								bit_cnt <= bit_cnt - 4'd1;
								shift_reg <= {shift_reg[14:0], 1'b0};
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				frogger_pkg::GAP: begin
					// Load cycle adds one more high cycle
					if (div_cnt == 2 * frogger_pkg::SCLK_HALF - 2) begin
						div_cnt <= '0;
						state <= (setup_idx < frogger_pkg::SETUP_COUNT) ?
							frogger_pkg::SETUP : frogger_pkg::IDLE;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= frogger_pkg::GAP;
			endcase
		end
	end

endmodule
